// ==== Bender.yml ====
package:
  name: audio_fifo_bridge

sources:
  - logic/audio_pkg.sv
  - logic/audio_req_edges.sv
  - logic/sample_fifo.sv
  - logic/audio_fifo_bridge.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_audio_fifo_bridge.sv

// ==== audio_fifo_bridge.f ====
+incdir+verif
logic/audio_pkg.sv
logic/audio_req_edges.sv
logic/sample_fifo.sv
logic/audio_fifo_bridge.sv
verif/tb_audio_fifo_bridge.sv

// ==== logic/audio_fifo_bridge.sv ====
`timescale 1ns/100ps

module audio_fifo_bridge
#(
	parameter int SAMPLE_W = 32,
	parameter int DEPTH    = 128
)
(
	input  logic                         CLOCK_50,
	input  logic                         ar,

	// Codec side
	input  logic                         adc_lrck,
	input  logic [SAMPLE_W-1:0]          adc_sample,
	input  logic                         dac_lrck,
	output logic [SAMPLE_W-1:0]          dac_sample,

	// Host side
	input  logic [audio_pkg::CTRL_W-1:0] host_ctrl,
	input  logic [SAMPLE_W-1:0]          host_dac_data,
	output logic [SAMPLE_W-1:0]          host_adc_data,
	output audio_pkg::audio_status_t     host_status
);

	//////////////////////////////
	// Internal signals
	//////////////////////////////

	// One-cycle requests per FIFO
	audio_pkg::fifo_req_t adc_req;
	audio_pkg::fifo_req_t dac_req;

	// Flags back from each FIFO
	audio_pkg::fifo_flags_t adc_flags;
	audio_pkg::fifo_flags_t dac_flags;

	//////////////////////////////
	// Request edges
	//////////////////////////////

	// Host levels and left/right clocks into pulses
	audio_req_edges u_req_edges
	(
		.CLOCK_50 (CLOCK_50),
		.ar       (ar),
		.host_ctrl(host_ctrl),
		.adc_lrck (adc_lrck),
		.dac_lrck (dac_lrck),
		.adc_req  (adc_req),
		.dac_req  (dac_req)
	);

	//////////////////////////////
	// Sample FIFOs
	//////////////////////////////

	// Codec to host
	sample_fifo #(
		.SAMPLE_W(SAMPLE_W),
		.DEPTH   (DEPTH)
	) adc_fifo
	(
		.CLOCK_50(CLOCK_50),
		.ar      (ar),
		.req     (adc_req),
		.data    (adc_sample),
		.q       (host_adc_data),
		.flags   (adc_flags)
	);

	// Host to codec
	sample_fifo #(
		.SAMPLE_W(SAMPLE_W),
		.DEPTH   (DEPTH)
	) dac_fifo
	(
		.CLOCK_50(CLOCK_50),
		.ar      (ar),
		.req     (dac_req),
		.data    (host_dac_data),
		.q       (dac_sample),
		.flags   (dac_flags)
	);

	//////////////////////////////
	// Status word
	//////////////////////////////

	// Reserved bits read as zero
	assign host_status = '{rsvd: '0, adc: adc_flags, dac: dac_flags};

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Clear level seen by the host empties that FIFO one cycle later
	a_adc_clear_empties: assert property (
		@(posedge CLOCK_50) disable iff (!ar)
		adc_req.clr |=> host_status.adc.empty
	);

	a_dac_clear_empties: assert property (
		@(posedge CLOCK_50) disable iff (!ar)
		dac_req.clr |=> host_status.dac.empty
	);

	// Sample written into an empty ADC FIFO reaches the host next cycle
	a_adc_fill_head: assert property (
		@(posedge CLOCK_50) disable iff (!ar)
		(adc_req.wr && !adc_req.clr && host_status.adc.empty)
			|=> (host_adc_data == $past(adc_sample))
	);

endmodule

// ==== logic/audio_pkg.sv ====
package audio_pkg;

	//////////////////////////////
	// Host interface widths
	//////////////////////////////

	// Control word from the host
	localparam int CTRL_W = 8;
	// Bits needed to index one control bit
	localparam int CTRL_IDX_W = $clog2(CTRL_W);

	// Status word back to the host
	localparam int STATUS_W = 16;

	//////////////////////////////
	// Control word layout
	//////////////////////////////

	// Bit positions inside host_ctrl
	// Clears act as levels, read and write act on the rising edge
	typedef enum logic [CTRL_IDX_W-1:0]
	{
		DAC_CLR = 0,
		ADC_CLR = 1,
		DAC_WR  = 2,
		ADC_RD  = 3
	} ctrl_bit_e;

	//////////////////////////////
	// FIFO side types
	//////////////////////////////

	// One-cycle requests into a single FIFO
	typedef struct packed
	{
		logic wr;
		logic rd;
		logic clr;
	} fifo_req_t;

	// Fill level flags of a single FIFO
	typedef struct packed
	{
		logic full;
		logic half;
		logic empty;
	} fifo_flags_t;

	// Unused upper bits of the status word
	localparam int RSVD_W = STATUS_W - 2 * $bits(fifo_flags_t);

	// Status word, ADC flags above DAC flags
	typedef struct packed
	{
		logic [RSVD_W-1:0] rsvd;
		fifo_flags_t       adc;
		fifo_flags_t       dac;
	} audio_status_t;

endpackage

// ==== logic/audio_req_edges.sv ====
`timescale 1ns/100ps

module audio_req_edges
(
	input  logic                         CLOCK_50,
	input  logic                         ar,
	input  logic [audio_pkg::CTRL_W-1:0] host_ctrl,
	input  logic                         adc_lrck,
	input  logic                         dac_lrck,
	output audio_pkg::fifo_req_t         adc_req,
	output audio_pkg::fifo_req_t         dac_req
);

	//////////////////////////////
	// Request levels
	//////////////////////////////

	// Host levels that become one-shot requests
	logic adc_rd_lvl;
	logic dac_wr_lvl;

	// Levels seen at the previous clock edge
	logic adc_rd_q;
	logic dac_wr_q;
	logic adc_lrck_q;
	logic dac_lrck_q;

	// Rising-edge pulses, one cycle wide
	logic adc_wr_pls;
	logic adc_rd_pls;
	logic dac_wr_pls;
	logic dac_rd_pls;

	// Pick the host bits by name
	assign adc_rd_lvl = host_ctrl[audio_pkg::ADC_RD];
	assign dac_wr_lvl = host_ctrl[audio_pkg::DAC_WR];

	// Previous-level registers
	// Cleared to 0, so a level already high out of reset fires once
	always_ff @(posedge CLOCK_50 or negedge ar)
	begin
		if (!ar)
		begin
			adc_rd_q   <= 1'b0;
			dac_wr_q   <= 1'b0;
			adc_lrck_q <= 1'b0;
			dac_lrck_q <= 1'b0;
		end
		else
		begin
			adc_rd_q   <= adc_rd_lvl;
			dac_wr_q   <= dac_wr_lvl;
			adc_lrck_q <= adc_lrck;
			dac_lrck_q <= dac_lrck;
		end
	end

	//////////////////////////////
	// Edge pulses
	//////////////////////////////

	// High now, low at the last edge
	// No register in the path, pulse valid in the same cycle
	assign adc_wr_pls = adc_lrck & ~adc_lrck_q;
	assign adc_rd_pls = adc_rd_lvl & ~adc_rd_q;
	assign dac_wr_pls = dac_wr_lvl & ~dac_wr_q;
	assign dac_rd_pls = dac_lrck & ~dac_lrck_q;

	// Route into the two request structs
	always_comb
	begin
		// Codec writes ADC samples, host reads them
		adc_req.wr  = adc_wr_pls;
		adc_req.rd  = adc_rd_pls;
		// Clear passes as a plain level
		adc_req.clr = host_ctrl[audio_pkg::ADC_CLR];

		// Host writes DAC samples, codec reads them
		dac_req.wr  = dac_wr_pls;
		dac_req.rd  = dac_rd_pls;
		dac_req.clr = host_ctrl[audio_pkg::DAC_CLR];
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A request pulse never lasts past one cycle
	property p_one_shot(logic pls);
		@(posedge CLOCK_50) disable iff (!ar)
		pls |=> !pls;
	endproperty

	a_adc_wr_one_shot: assert property (p_one_shot(adc_req.wr));
	a_adc_rd_one_shot: assert property (p_one_shot(adc_req.rd));
	a_dac_wr_one_shot: assert property (p_one_shot(dac_req.wr));
	a_dac_rd_one_shot: assert property (p_one_shot(dac_req.rd));

endmodule

// ==== logic/sample_fifo.sv ====
`timescale 1ns/100ps

module sample_fifo
#(
	parameter int SAMPLE_W = 32,
	parameter int DEPTH    = 128
)
(
	input  logic                   CLOCK_50,
	input  logic                   ar,
	input  audio_pkg::fifo_req_t   req,
	input  logic [SAMPLE_W-1:0]    data,
	output logic [SAMPLE_W-1:0]    q,
	output audio_pkg::fifo_flags_t flags
);

	// Pointer width, DEPTH is a power of two
	localparam int AW = $clog2(DEPTH);
	// One more bit so a full FIFO can be counted
	localparam int CNT_W = AW + 1;

	//////////////////////////////
	// Storage and pointers
	//////////////////////////////

	// Sample storage
	logic [SAMPLE_W-1:0] mem [DEPTH];

	// Next slot to write, oldest slot to read
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// Slot after the oldest one, wraps at DEPTH
	logic [AW-1:0] rd_ptr_inc;

	// Words held
	logic [CNT_W-1:0] count;

	// Requests that actually take effect this cycle
	logic do_wr;
	logic do_rd;

	assign rd_ptr_inc = rd_ptr + 1'b1;

	// Clear beats both read and write
	// Read from empty is dropped
	assign do_rd = req.rd && !req.clr && (count != '0);
	// Write to full is dropped
	assign do_wr = req.wr && !req.clr && (count != CNT_W'(DEPTH));

	//////////////////////////////
	// Control state
	//////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge ar)
	begin
		if (!ar)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (req.clr)
		begin
			// Drop everything, back to the reset layout
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr_inc;

			// Read plus write leaves the count alone
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Memory write port
	always_ff @(posedge CLOCK_50)
	begin
		if (do_wr)
			mem[wr_ptr] <= data;
	end

	//////////////////////////////
	// Head register
	//////////////////////////////

	// q always shows the oldest word, first-word-fall-through
	// Holds its last value while the FIFO is empty
	always_ff @(posedge CLOCK_50 or negedge ar)
	begin
		if (!ar)
			q <= '0;
		else if (do_rd && (count > CNT_W'(1)))
			// Next oldest word already sits in memory
			q <= mem[rd_ptr_inc];
		else if (do_wr && ((count == '0) || do_rd))
			// New word becomes the head straight away
			q <= data;
	end

	//////////////////////////////
	// Flags
	//////////////////////////////

	// Decoded from the registered count, one cycle behind the request
	always_comb
	begin
		flags.full  = (count == CNT_W'(DEPTH));
		flags.half  = (count >= CNT_W'(DEPTH / 2));
		flags.empty = (count == '0);
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Count stays inside the storage
	a_count_range: assert property (
		@(posedge CLOCK_50) disable iff (!ar)
		count <= CNT_W'(DEPTH)
	);

	// Never full and empty at once
	a_full_not_empty: assert property (
		@(posedge CLOCK_50) disable iff (!ar)
		!(flags.full && flags.empty)
	);

endmodule

// ==== verif/tb_audio_tasks.svh ====
//////////////////////////////
// Stimulus helpers
//////////////////////////////

// Xorshift32 step, next sample value
function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// Control word with one named bit set
function automatic logic [audio_pkg::CTRL_W-1:0] ctrl_bit(input audio_pkg::ctrl_bit_e b);
	logic [audio_pkg::CTRL_W-1:0] m;
	m    = '0;
	m[b] = 1'b1;
	return m;
endfunction

//////////////////////////////
// Expected values
//////////////////////////////

// Flags from a word count
function automatic audio_pkg::fifo_flags_t flags_for(input int words);
	audio_pkg::fifo_flags_t f;
	f.full  = (words == DEPTH);
	f.half  = (words >= DEPTH / 2);
	f.empty = (words == 0);
	return f;
endfunction

// Whole status word from both model queues
function automatic audio_pkg::audio_status_t expected_status();
	audio_pkg::audio_status_t s;
	s     = '0;
	s.adc = flags_for(adc_model.size());
	s.dac = flags_for(dac_model.size());
	return s;
endfunction

// Apply one cycle of requests to both queues
task automatic update_models(input logic [audio_pkg::CTRL_W-1:0] ctrl, input logic adc_edge,
	input logic [SAMPLE_W-1:0] adc_data, input logic dac_edge,
	input logic [SAMPLE_W-1:0] dac_data);
	logic rd_ok;
	logic wr_ok;
	// ADC side, codec writes and host reads
	if (ctrl[audio_pkg::ADC_CLR])
		adc_model.delete();
	else
	begin
		rd_ok = ctrl[audio_pkg::ADC_RD] && (adc_model.size() > 0);
		wr_ok = adc_edge && (adc_model.size() < DEPTH);
		if (rd_ok)
			void'(adc_model.pop_front());
		if (wr_ok)
			adc_model.push_back(adc_data);
	end
	// DAC side, host writes and codec reads
	if (ctrl[audio_pkg::DAC_CLR])
		dac_model.delete();
	else
	begin
		rd_ok = dac_edge && (dac_model.size() > 0);
		wr_ok = ctrl[audio_pkg::DAC_WR] && (dac_model.size() < DEPTH);
		if (rd_ok)
			void'(dac_model.pop_front());
		if (wr_ok)
			dac_model.push_back(dac_data);
	end
	// Empty FIFO keeps its last head
	if (adc_model.size() > 0)
		adc_head = adc_model[0];
	if (dac_model.size() > 0)
		dac_head = dac_model[0];
endtask

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_status(input string name, input audio_pkg::audio_status_t expected,
	input audio_pkg::audio_status_t actual);
	if (actual !== expected)
		report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
endtask

task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] expected,
	input logic [SAMPLE_W-1:0] actual);
	if (actual !== expected)
		report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
endtask

// Status and both heads against the models
task automatic check_outputs();
	check_status("host_status", expected_status(), host_status);
	check_sample("host_adc_data", adc_head, host_adc_data);
	check_sample("dac_sample", dac_head, dac_sample);
endtask

//////////////////////////////
// Drive tasks
//////////////////////////////

// Raise levels at one edge, drop them at the next, check at the falling edge after
task automatic run_op(input logic [audio_pkg::CTRL_W-1:0] ctrl, input logic adc_edge,
	input logic [SAMPLE_W-1:0] adc_data, input logic dac_edge,
	input logic [SAMPLE_W-1:0] dac_data);
	@(posedge CLOCK_50);
	host_ctrl     <= ctrl;
	adc_lrck      <= adc_edge;
	adc_sample    <= adc_data;
	dac_lrck      <= dac_edge;
	host_dac_data <= dac_data;
	@(posedge CLOCK_50);
	host_ctrl <= '0;
	adc_lrck  <= 1'b0;
	dac_lrck  <= 1'b0;
	update_models(ctrl, adc_edge, adc_data, dac_edge, dac_data);
	@(negedge CLOCK_50);
	check_outputs();
endtask

task automatic adc_write(input logic [SAMPLE_W-1:0] s);
	run_op('0, 1'b1, s, 1'b0, '0);
endtask

task automatic adc_read();
	run_op(ctrl_bit(audio_pkg::ADC_RD), 1'b0, '0, 1'b0, '0);
endtask

task automatic dac_write(input logic [SAMPLE_W-1:0] s);
	run_op(ctrl_bit(audio_pkg::DAC_WR), 1'b0, '0, 1'b0, s);
endtask

task automatic dac_read();
	run_op('0, 1'b0, '0, 1'b1, '0);
endtask

// DAC_WR held high for 5 cycles, one word only
task automatic hold_dac_write(input logic [SAMPLE_W-1:0] s);
	@(posedge CLOCK_50);
	host_ctrl     <= ctrl_bit(audio_pkg::DAC_WR);
	host_dac_data <= s;
	update_models(ctrl_bit(audio_pkg::DAC_WR), 1'b0, '0, 1'b0, s);
	repeat (4)
	begin
		@(posedge CLOCK_50);
		@(negedge CLOCK_50);
		check_outputs();
	end
	@(posedge CLOCK_50);
	host_ctrl <= '0;
	@(negedge CLOCK_50);
	check_outputs();
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

// Both empty flags only, heads at zero
task automatic verify_reset_state();
	@(negedge CLOCK_50);
	check_status("host_status", audio_pkg::audio_status_t'(16'h0009), host_status);
	check_outputs();
endtask

task automatic stream_adc_path();
	repeat (20) adc_write(SAMPLE_W'(next_random()));
	repeat (20) adc_read();
endtask

task automatic stream_dac_path();
	repeat (10) dac_write(SAMPLE_W'(next_random()));
	repeat (10) dac_read();
	hold_dac_write(SAMPLE_W'(next_random()));
	dac_read();
endtask

// Half at DEPTH/2, full at DEPTH, last 3 writes lost
task automatic overflow_adc_fifo();
	repeat (DEPTH + 3) adc_write(SAMPLE_W'(next_random()));
	repeat (DEPTH) adc_read();
	// Read on empty, head must hold
	adc_read();
endtask

// ADC clear beats a write in the same cycle, DAC untouched
task automatic clear_fifos();
	repeat (5) adc_write(SAMPLE_W'(next_random()));
	repeat (5) dac_write(SAMPLE_W'(next_random()));
	run_op(ctrl_bit(audio_pkg::ADC_CLR), 1'b1, SAMPLE_W'(next_random()), 1'b0, '0);
	run_op(ctrl_bit(audio_pkg::DAC_CLR), 1'b0, '0, 1'b0, '0);
endtask

// Read and write together keep the count
task automatic overlap_read_write();
	repeat (3) adc_write(SAMPLE_W'(next_random()));
	repeat (6) run_op(ctrl_bit(audio_pkg::ADC_RD), 1'b1, SAMPLE_W'(next_random()), 1'b0, '0);
	repeat (3) adc_read();
endtask

// ==== verif/tb_audio_fifo_bridge.sv ====
`timescale 1ns/100ps

module tb_audio_fifo_bridge;

	// Sizing handed to the DUT and used by the models
	localparam int SAMPLE_W = 32;
	localparam int DEPTH    = 128;
	// About 350 operations at two cycles each, plenty of margin
	localparam int TIMEOUT_CYCLES = 4000;

	//////////////////////////////
	// DUT signals
	//////////////////////////////

	logic                         CLOCK_50;
	logic                         ar;
	logic                         adc_lrck;
	logic [SAMPLE_W-1:0]          adc_sample;
	logic                         dac_lrck;
	logic [SAMPLE_W-1:0]          dac_sample;
	logic [audio_pkg::CTRL_W-1:0] host_ctrl;
	logic [SAMPLE_W-1:0]          host_dac_data;
	logic [SAMPLE_W-1:0]          host_adc_data;
	audio_pkg::audio_status_t     host_status;

	// Reference queues, oldest word first
	logic [SAMPLE_W-1:0] adc_model[$];
	logic [SAMPLE_W-1:0] dac_model[$];
	// Expected heads, these hold while a FIFO is empty
	logic [SAMPLE_W-1:0] adc_head;
	logic [SAMPLE_W-1:0] dac_head;

	// Xorshift state
	logic [31:0] rng_state;
	int          cycle_count;

	audio_fifo_bridge #(
		.SAMPLE_W(SAMPLE_W),
		.DEPTH   (DEPTH)
	) DUT
	(
		.CLOCK_50     (CLOCK_50),
		.ar           (ar),
		.adc_lrck     (adc_lrck),
		.adc_sample   (adc_sample),
		.dac_lrck     (dac_lrck),
		.dac_sample   (dac_sample),
		.host_ctrl    (host_ctrl),
		.host_dac_data(host_dac_data),
		.host_adc_data(host_adc_data),
		.host_status  (host_status)
	);

	// Print the cause, then end the run
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	`include "tb_audio_tasks.svh"

	//////////////////////////////
	// Clock and watchdog
	//////////////////////////////

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			report_failure("Timeout, the tests did not finish within the cycle limit");
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		rng_state     = 32'd21720;
		cycle_count   = 0;
		adc_head      = '0;
		dac_head      = '0;
		ar            = 1'b0;
		adc_lrck      = 1'b0;
		adc_sample    = '0;
		dac_lrck      = 1'b0;
		host_ctrl     = '0;
		host_dac_data = '0;

		// Reset held for 16 cycles
		repeat (16) @(posedge CLOCK_50);
		ar <= 1'b1;

		verify_reset_state();
		stream_adc_path();
		stream_dac_path();
		overflow_adc_fifo();
		clear_fifos();
		overlap_read_write();

		$display("Simulation passed");
		$finish;
	end

endmodule
